// ==== build.f ====
+incdir+common
common/rs_pkg.sv
rs/rs_entry.sv
rs/rs_station.sv
hw/issue_arbiter.sv
hw/issue_stage_top.sv
verif/tb_clock_gen.sv
verif/tb_issue_stage.sv

// ==== common/rs_cfg.svh ====
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// physical register tag width, tag 0 is the hardwired zero register
`define RS_PHY_BITS    6

`define RS_CDB_WIDTH   2   // result ports on the common data bus
`define RS_DEPTH       4   // entries per reservation station

// one path per CDB port plus the fast bypass as the last path
`define RS_NUM_BYP     (`RS_CDB_WIDTH + 1)

// payload field widths
`define RS_ROB_BITS    5
`define RS_ALU_OP_BITS 4
`define RS_IMM_BITS    16
`define RS_MEM_SZ_BITS 2
`define RS_OFFS_BITS   12

`endif

// ==== common/rs_pkg.sv ====
`include "rs_cfg.svh"

package rs_pkg;

    typedef logic [`RS_PHY_BITS-1:0] phy_tag_t;

    // integer micro-op as held in the integer station
    typedef struct packed {
        phy_tag_t                   rs1_phy;
        logic                       rs1_valid;
        phy_tag_t                   rs2_phy;
        logic                       rs2_valid;
        phy_tag_t                   rd_phy;
        logic [`RS_ALU_OP_BITS-1:0] alu_op;
        logic [`RS_IMM_BITS-1:0]    imm;
        logic [`RS_ROB_BITS-1:0]    rob_id;
    } int_rs_entry_t;

    // load/store micro-op, rs2 carries the store data source
    typedef struct packed {
        phy_tag_t                   rs1_phy;
        logic                       rs1_valid;
        phy_tag_t                   rs2_phy;
        logic                       rs2_valid;
        phy_tag_t                   rd_phy;
        logic                       is_store;
        logic [`RS_MEM_SZ_BITS-1:0] mem_size;  // 0 byte .. 3 double
        logic [`RS_OFFS_BITS-1:0]   offset;
        logic [`RS_ROB_BITS-1:0]    rob_id;
    } mem_rs_entry_t;

    // one bit per forwarding path for each source operand
    // bits [RS_CDB_WIDTH-1:0] are the CDB ports, the top bit is the fast bypass
    typedef struct packed {
        logic [`RS_NUM_BYP-1:0] rs1_byp_en;
        logic [`RS_NUM_BYP-1:0] rs2_byp_en;
    } bypass_t;

endpackage

// ==== hw/issue_arbiter.sv ====
`timescale 1ns/1ps
`include "rs_cfg.svh"

module issue_arbiter
    import rs_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          int_cand_valid,
    input  int_rs_entry_t int_cand_entry,
    input  bypass_t       int_cand_bypass,
    input  logic          mem_cand_valid,
    input  mem_rs_entry_t mem_cand_entry,
    input  bypass_t       mem_cand_bypass,
    output logic          int_grant,
    output logic          mem_grant,
    output logic          fast_valid,
    output phy_tag_t      fast_rd,
    output logic          issue_valid,
    output logic          issue_is_mem,
    output int_rs_entry_t issue_int_entry,
    output mem_rs_entry_t issue_mem_entry,
    output bypass_t       issue_bypass
);

    logic last_win_int;   // set when the integer station won the last contest

    // round robin between two requesters
    assign int_grant = int_cand_valid && (!mem_cand_valid || !last_win_int);
    assign mem_grant = mem_cand_valid && !int_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_win_int <= 1'b0;   // integer station goes first
        end else if (int_grant) begin
            last_win_int <= 1'b1;
        end else if (mem_grant) begin
            last_win_int <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid  <= 1'b0;
            issue_is_mem <= 1'b0;
        end else begin
            issue_valid  <= int_grant || mem_grant;
            issue_is_mem <= mem_grant;
        end
    end

    // issue payload, each side only loads when its station wins
    always_ff @(posedge clk) begin
        if (int_grant) begin
            issue_int_entry <= int_cand_entry;
        end
        if (mem_grant) begin
            issue_mem_entry <= mem_cand_entry;
        end
        issue_bypass <= mem_grant ? mem_cand_bypass : int_cand_bypass;
    end

    // destination of the integer op in the issue register, seen by both stations
    assign fast_rd    = issue_int_entry.rd_phy;
    assign fast_valid = issue_valid && !issue_is_mem && (issue_int_entry.rd_phy != '0);

endmodule

// ==== hw/issue_stage_top.sv ====
`timescale 1ns/1ps
`include "rs_cfg.svh"

module issue_stage_top
    import rs_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     int_push,
    input  int_rs_entry_t            int_push_entry,
    input  logic                     mem_push,
    input  mem_rs_entry_t            mem_push_entry,
    input  logic [`RS_CDB_WIDTH-1:0] cdb_valid,
    input  phy_tag_t                 cdb_rd [`RS_CDB_WIDTH],
    output logic                     int_full,
    output logic                     mem_full,
    output logic                     issue_valid,
    output logic                     issue_is_mem,
    output int_rs_entry_t            issue_int_entry,
    output mem_rs_entry_t            issue_mem_entry,
    output bypass_t                  issue_bypass
);

    logic          int_cand_valid;
    int_rs_entry_t int_cand_entry;
    bypass_t       int_cand_bypass;
    logic          int_grant;

    logic          mem_cand_valid;
    mem_rs_entry_t mem_cand_entry;
    bypass_t       mem_cand_bypass;
    logic          mem_grant;

    logic          fast_valid;   // fed back to both stations
    phy_tag_t      fast_rd;

    rs_station #(
        .RS_ENTRY_T (int_rs_entry_t)
    ) int_rs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (int_push),
        .push_entry  (int_push_entry),
        .cdb_valid   (cdb_valid),
        .cdb_rd      (cdb_rd),
        .fast_valid  (fast_valid),
        .fast_rd     (fast_rd),
        .grant       (int_grant),
        .full        (int_full),
        .cand_valid  (int_cand_valid),
        .cand_entry  (int_cand_entry),
        .cand_bypass (int_cand_bypass)
    );

    rs_station #(
        .RS_ENTRY_T (mem_rs_entry_t)
    ) mem_rs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (mem_push),
        .push_entry  (mem_push_entry),
        .cdb_valid   (cdb_valid),
        .cdb_rd      (cdb_rd),
        .fast_valid  (fast_valid),
        .fast_rd     (fast_rd),
        .grant       (mem_grant),
        .full        (mem_full),
        .cand_valid  (mem_cand_valid),
        .cand_entry  (mem_cand_entry),
        .cand_bypass (mem_cand_bypass)
    );

    issue_arbiter arb0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .int_cand_valid  (int_cand_valid),
        .int_cand_entry  (int_cand_entry),
        .int_cand_bypass (int_cand_bypass),
        .mem_cand_valid  (mem_cand_valid),
        .mem_cand_entry  (mem_cand_entry),
        .mem_cand_bypass (mem_cand_bypass),
        .int_grant       (int_grant),
        .mem_grant       (mem_grant),
        .fast_valid      (fast_valid),
        .fast_rd         (fast_rd),
        .issue_valid     (issue_valid),
        .issue_is_mem    (issue_is_mem),
        .issue_int_entry (issue_int_entry),
        .issue_mem_entry (issue_mem_entry),
        .issue_bypass    (issue_bypass)
    );

endmodule

// ==== rs/rs_entry.sv ====
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_entry
    import rs_pkg::*;
#(
    parameter type RS_ENTRY_T = int_rs_entry_t
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push_en,
    input  RS_ENTRY_T                entry_in,
    input  logic                     grant,
    input  logic [`RS_CDB_WIDTH-1:0] cdb_valid,
    input  phy_tag_t                 cdb_rd [`RS_CDB_WIDTH],
    input  logic                     fast_valid,
    input  phy_tag_t                 fast_rd,
    output logic                     valid,
    output logic                     request,
    output RS_ENTRY_T                entry,
    output bypass_t                  byp
);

    logic      valid_q;
    RS_ENTRY_T entry_q;
    RS_ENTRY_T entry_woken;   // stored payload with this cycle's CDB wakeups applied
    logic      rs1_ready;
    logic      rs2_ready;
    logic      fast_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (push_en) begin
            valid_q <= 1'b1;
        end else if (grant) begin
            valid_q <= 1'b0;   // leaves for the issue register
        end
    end

    // a fresh push replaces the payload, otherwise keep the woken copy
    always_ff @(posedge clk) begin
        if (push_en) begin
            entry_q <= entry_in;
        end else begin
            entry_q <= entry_woken;
        end
    end

    // CDB wakeup, a tag 0 match still marks the operand valid
    always_comb begin
        entry_woken = entry_q;
        for (int k = 0; k < `RS_CDB_WIDTH; k++) begin
            if (cdb_valid[k]) begin
                if (entry_q.rs1_phy == cdb_rd[k]) begin
                    entry_woken.rs1_valid = 1'b1;
                end
                if (entry_q.rs2_phy == cdb_rd[k]) begin
                    entry_woken.rs2_valid = 1'b1;
                end
            end
        end
    end

    assign fast_hit = fast_valid && (fast_rd != '0);

    // forwarding path detection, the zero register never needs a bypass
    always_comb begin
        byp = '0;
        for (int k = 0; k < `RS_CDB_WIDTH; k++) begin
            byp.rs1_byp_en[k] = cdb_valid[k] && (cdb_rd[k] != '0) &&
                                (entry_q.rs1_phy == cdb_rd[k]);
            byp.rs2_byp_en[k] = cdb_valid[k] && (cdb_rd[k] != '0) &&
                                (entry_q.rs2_phy == cdb_rd[k]);
        end
        byp.rs1_byp_en[`RS_CDB_WIDTH] = fast_hit && (entry_q.rs1_phy == fast_rd);
        byp.rs2_byp_en[`RS_CDB_WIDTH] = fast_hit && (entry_q.rs2_phy == fast_rd);
    end

    assign rs1_ready = entry_q.rs1_valid || (|byp.rs1_byp_en);
    assign rs2_ready = entry_q.rs2_valid || (|byp.rs2_byp_en);

    assign request = valid_q && rs1_ready && rs2_ready;
    assign valid   = valid_q;
    assign entry   = entry_woken;   // issued op carries same-cycle CDB wakeups

endmodule

// ==== rs/rs_station.sv ====
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_station
    import rs_pkg::*;
#(
    parameter type RS_ENTRY_T = int_rs_entry_t
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  RS_ENTRY_T                push_entry,
    input  logic [`RS_CDB_WIDTH-1:0] cdb_valid,
    input  phy_tag_t                 cdb_rd [`RS_CDB_WIDTH],
    input  logic                     fast_valid,
    input  phy_tag_t                 fast_rd,
    input  logic                     grant,
    output logic                     full,
    output logic                     cand_valid,
    output RS_ENTRY_T                cand_entry,
    output bypass_t                  cand_bypass
);

    localparam int IDX_W = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

    logic [`RS_DEPTH-1:0] ent_valid;
    logic [`RS_DEPTH-1:0] ent_req;
    logic [`RS_DEPTH-1:0] ent_push;
    logic [`RS_DEPTH-1:0] ent_grant;
    RS_ENTRY_T            ent_data [`RS_DEPTH];
    bypass_t              ent_byp [`RS_DEPTH];

    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     cand_idx;

    assign full       = &ent_valid;
    assign cand_valid = |ent_req;

    // lowest free slot, scanned from the top so the last hit wins
    always_comb begin
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // oldest-ready pick, age is approximated by entry index
    always_comb begin
        cand_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (ent_req[i]) begin
                cand_idx = IDX_W'(i);
            end
        end
    end

    assign cand_entry  = ent_data[cand_idx];
    assign cand_bypass = ent_byp[cand_idx];

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_ent
        // push while full is dropped
        assign ent_push[i]  = push && !full && (free_idx == IDX_W'(i));
        assign ent_grant[i] = grant && cand_valid && (cand_idx == IDX_W'(i));

        rs_entry #(
            .RS_ENTRY_T (RS_ENTRY_T)
        ) ent (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_en    (ent_push[i]),
            .entry_in   (push_entry),
            .grant      (ent_grant[i]),
            .cdb_valid  (cdb_valid),
            .cdb_rd     (cdb_rd),
            .fast_valid (fast_valid),
            .fast_rd    (fast_rd),
            .valid      (ent_valid[i]),
            .request    (ent_req[i]),
            .entry      (ent_data[i]),
            .byp        (ent_byp[i])
        );
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f build.f --top-module tb_issue_stage -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// ==== verif/issue_patterns.txt ====
// w0 {test, 0, 0, int_push mem_push cdb_valid[1:0]}  w1 int {rs1, rs2}  w2 int {rd, rob}
// w3 mem {rs1, rs2}  w4 mem {rd, rob}  w5 {cdb_rd1, cdb_rd0}  w6 {exp flags, exp rob}  w7 {byp1, byp2}
1008 8182 0A01 0000 0000 0000 0000 0000
1000 0000 0000 0000 0000 0000 0000 0000
1000 0000 0000 0000 0000 0000 3801 0000
1000 0000 0000 0000 0000 0000 0000 0000
2008 1400 0002 0000 0000 0000 0000 0000
2001 0000 0000 0000 0000 0000 0000 0000
2002 0000 0000 0000 0000 1400 0000 0000
2000 0000 0000 0000 0000 0000 3802 0200
3008 8485 1E03 0000 0000 0000 0000 0000
3008 1E1E 0005 0000 0000 0000 0000 0000
3000 0000 0000 0000 0000 0000 3803 0000
3000 0000 0000 0000 0000 0000 0805 0404
300C 8687 1F06 1F80 0004 0000 0000 0000
3000 0000 0000 0000 0000 0000 0000 0000
3000 0000 0000 0000 0000 0000 3806 0000
3000 0000 0000 0000 0000 0000 1C04 0400
400C 8182 0007 8182 0008 0000 0000 0000
400C 8182 0009 8182 000A 0000 0000 0000
4000 0000 0000 0000 0000 0000 3807 0000
4000 0000 0000 0000 0000 0000 3C08 0000
4000 0000 0000 0000 0000 0000 3809 0000
4000 0000 0000 0000 0000 0000 3C0A 0000
5008 2881 000B 0000 0000 0000 0000 0000
5008 2881 000C 0000 0000 0000 0000 0000
5008 2881 000D 0000 0000 0000 0000 0000
5008 2881 000E 0000 0000 0000 0000 0000
5001 0000 0000 0000 0000 0028 0200 0000
5000 0000 0000 0000 0000 0000 380B 0100
5000 0000 0000 0000 0000 0000 380C 0000
5000 0000 0000 0000 0000 0000 380D 0000
5000 0000 0000 0000 0000 0000 380E 0000
5000 0000 0000 0000 0000 0000 0000 0000

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,   // 20 ns clock
    parameter int RST_CYCLES  = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // synchronous reset, released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== verif/tb_issue_stage.sv ====
`timescale 1ns/1ps
`include "rs_cfg.svh"

module tb_issue_stage
    import rs_pkg::*;
();

    localparam int NW        = 8;    // words per pattern line
    localparam int MAX_LINES = 64;

    logic                     clk;
    logic                     rst_n;
    logic                     int_push;
    int_rs_entry_t            int_push_entry;
    logic                     mem_push;
    mem_rs_entry_t            mem_push_entry;
    logic [`RS_CDB_WIDTH-1:0] cdb_valid;
    phy_tag_t                 cdb_rd [`RS_CDB_WIDTH];
    logic                     int_full;
    logic                     mem_full;
    logic                     issue_valid;
    logic                     issue_is_mem;
    int_rs_entry_t            issue_int_entry;
    mem_rs_entry_t            issue_mem_entry;
    bypass_t                  issue_bypass;

    logic [15:0]   pat [0:NW*MAX_LINES-1];
    int_rs_entry_t int_tab [32];   // pushed ops by rob_id
    mem_rs_entry_t mem_tab [32];
    int            n_lines;
    int            pass_count;
    int            fail_count;
    int            cycles;

    tb_clock_gen clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_stage_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .int_push        (int_push),
        .int_push_entry  (int_push_entry),
        .mem_push        (mem_push),
        .mem_push_entry  (mem_push_entry),
        .cdb_valid       (cdb_valid),
        .cdb_rd          (cdb_rd),
        .int_full        (int_full),
        .mem_full        (mem_full),
        .issue_valid     (issue_valid),
        .issue_is_mem    (issue_is_mem),
        .issue_int_entry (issue_int_entry),
        .issue_mem_entry (issue_mem_entry),
        .issue_bypass    (issue_bypass)
    );

    // source byte is {valid, 1'b0, tag}
    // the other payload fields are derived from the rob_id
    function automatic int_rs_entry_t make_int_op(input logic [7:0] s1, input logic [7:0] s2,
                                                  input logic [7:0] rd, input logic [7:0] rob);
        int_rs_entry_t e;
        e.rs1_phy   = s1[`RS_PHY_BITS-1:0];
        e.rs1_valid = s1[7];
        e.rs2_phy   = s2[`RS_PHY_BITS-1:0];
        e.rs2_valid = s2[7];
        e.rd_phy    = rd[`RS_PHY_BITS-1:0];
        e.alu_op    = rob[`RS_ALU_OP_BITS-1:0];
        e.imm       = {rob, rob} ^ 16'h5a3c;
        e.rob_id    = rob[`RS_ROB_BITS-1:0];
        return e;
    endfunction

    function automatic mem_rs_entry_t make_mem_op(input logic [7:0] s1, input logic [7:0] s2,
                                                  input logic [7:0] rd, input logic [7:0] rob);
        mem_rs_entry_t e;
        e.rs1_phy   = s1[`RS_PHY_BITS-1:0];
        e.rs1_valid = s1[7];
        e.rs2_phy   = s2[`RS_PHY_BITS-1:0];
        e.rs2_valid = s2[7];
        e.rd_phy    = rd[`RS_PHY_BITS-1:0];
        e.is_store  = rob[0];
        e.mem_size  = rob[2:1];
        e.offset    = {rob[3:0], rob} ^ 12'ha5c;
        e.rob_id    = rob[`RS_ROB_BITS-1:0];
        return e;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_int_entry(input string name, input int_rs_entry_t exp,
                                   input int_rs_entry_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_mem_entry(input string name, input mem_rs_entry_t exp,
                                   input mem_rs_entry_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bypass(input string name, input bypass_t exp, input bypass_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic drive_line(input int i);
        logic [15:0] w [NW];
        for (int k = 0; k < NW; k++) begin
            w[k] = pat[i*NW + k];
        end
        int_push       = w[0][3];
        mem_push       = w[0][2];
        cdb_valid      = w[0][1:0];
        int_push_entry = make_int_op(w[1][15:8], w[1][7:0], w[2][15:8], w[2][7:0]);
        mem_push_entry = make_mem_op(w[3][15:8], w[3][7:0], w[4][15:8], w[4][7:0]);
        cdb_rd[0]      = w[5][`RS_PHY_BITS-1:0];
        cdb_rd[1]      = w[5][8 +: `RS_PHY_BITS];
        if (int_push) begin
            int_tab[w[2][4:0]] = int_push_entry;
        end
        if (mem_push) begin
            mem_tab[w[4][4:0]] = mem_push_entry;
        end
    endtask

    task automatic check_line(input int i);
        logic [7:0]    flags;
        logic [4:0]    rob;
        int_rs_entry_t exp_int;
        mem_rs_entry_t exp_mem;
        bypass_t       exp_byp;
        flags = pat[i*NW + 6][15:8];
        rob   = pat[i*NW + 6][4:0];
        exp_byp.rs1_byp_en = pat[i*NW + 7][8 +: `RS_NUM_BYP];
        exp_byp.rs2_byp_en = pat[i*NW + 7][0 +: `RS_NUM_BYP];
        check_bit("int_full", flags[1], int_full);
        check_bit("mem_full", flags[0], mem_full);
        check_bit("issue_valid", flags[3], issue_valid);
        if (flags[3]) begin
            check_bit("issue_is_mem", flags[2], issue_is_mem);
            check_bypass("issue_bypass", exp_byp, issue_bypass);
            if (flags[2]) begin
                exp_mem           = mem_tab[rob];
                exp_mem.rs1_valid = flags[5];
                exp_mem.rs2_valid = flags[4];
                check_mem_entry("issue_mem_entry", exp_mem, issue_mem_entry);
            end else begin
                exp_int           = int_tab[rob];
                exp_int.rs1_valid = flags[5];
                exp_int.rs2_valid = flags[4];
                check_int_entry("issue_int_entry", exp_int, issue_int_entry);
            end
        end
    endtask

    // run length guard counting cycles after reset
    initial begin
        cycles = 0;
        wait (rst_n === 1'b1);
        while (cycles <= n_lines + 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run hung after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int cur_test;
        int test_fails;
        int_push       = 1'b0;
        mem_push       = 1'b0;
        int_push_entry = '0;
        mem_push_entry = '0;
        cdb_valid      = '0;
        cdb_rd[0]      = '0;
        cdb_rd[1]      = '0;
        pass_count     = 0;
        fail_count     = 0;
        for (int k = 0; k < NW*MAX_LINES; k++) begin
            pat[k] = {4'hf, 12'(k)};   // unread words carry test nibble f over their address
        end
        $readmemh("verif/issue_patterns.txt", pat);
        n_lines = 0;
        while (n_lines < MAX_LINES && pat[n_lines*NW][15:12] != 4'hf) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("no pattern lines could be read");
            fail_count++;
        end

        wait (rst_n === 1'b1);
        cur_test   = (n_lines > 0) ? int'(pat[0][15:12]) : 0;
        test_fails = fail_count;
        for (int i = 0; i < n_lines; i++) begin
            if (int'(pat[i*NW][15:12]) != cur_test) begin
                $display("test %0d done, %0d errors", cur_test, fail_count - test_fails);
                cur_test   = int'(pat[i*NW][15:12]);
                test_fails = fail_count;
            end
            @(posedge clk);
            #1 drive_line(i);
            #18 check_line(i);   // just before the next edge
        end
        if (n_lines > 0) begin
            $display("test %0d done, %0d errors", cur_test, fail_count - test_fails);
        end

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
